//--- simd_alu_consts.svh
// SIMD ALU constants
// Operand geometry, queue depth and opcode width shared by the whole design

`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////

// Operand and result width in bits
`define SIMD_ELEN 64

// Bytes per operand, one saturation flag each
`define SIMD_STRB_W 8

////////////////////////////////////////
// Control
////////////////////////////////////////

// Pending operations held between issue and execution
`define SIMD_OP_FIFO_DEPTH 4

`define SIMD_OP_W 4

`endif

//--- simd_lane_pkg.sv
// SIMD lane layout package
// Element width codes, operand word and per-byte saturation flags

`include "simd_alu_consts.svh"

package simd_lane_pkg;

  ////////////////////////////////////////
  // Element width
  ////////////////////////////////////////

  // Lane size in bits is 8 << code
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  ////////////////////////////////////////
  // Data words
  ////////////////////////////////////////

  // Operand or result, read as lanes of the element width
  typedef logic [`SIMD_ELEN-1:0] elen_t;

  // One flag per byte, a saturated lane flags all of its bytes
  typedef logic [`SIMD_STRB_W-1:0] vxsat_t;

endpackage

//--- alu_op_pkg.sv
// ALU operation package
// Opcode set of the SIMD ALU and opcode classification helpers

`include "simd_alu_consts.svh"

package alu_op_pkg;

  typedef enum logic [`SIMD_OP_W-1:0] {
    // Logical
    VAND   = 4'h0,
    VOR    = 4'h1,
    VXOR   = 4'h2,
    // Wrapping arithmetic, VSUB is b - a
    VADD   = 4'h3,
    VSUB   = 4'h4,
    VRSUB  = 4'h5,
    // Saturating arithmetic
    VSADDU = 4'h6,
    VSADD  = 4'h7,
    VSSUBU = 4'h8,
    // Min and max
    VMIN   = 4'h9,
    VMINU  = 4'hA,
    VMAX   = 4'hB,
    VMAXU  = 4'hC,
    // Shifts of b by a
    VSLL   = 4'hD,
    VSRL   = 4'hE,
    VSRA   = 4'hF
  } alu_op_e;

  // Lanes compared as two's complement values
  function automatic logic is_signed_cmp(alu_op_e op);
    return op inside {VMIN, VMAX};
  endfunction

  function automatic logic is_max(alu_op_e op);
    return op inside {VMAX, VMAXU};
  endfunction

endpackage

//--- alu_op_if.sv
// ALU operation channel
// Carries one queued operation with a valid/ready handshake

`timescale 1ns/1ps

interface alu_op_if;

  logic                   valid;
  logic                   ready;
  alu_op_pkg::alu_op_e    op;
  simd_lane_pkg::vew_e    vew;
  simd_lane_pkg::elen_t   opa;
  simd_lane_pkg::elen_t   opb;

  // Payload is held from valid until the transfer
  modport producer (
    output valid,
    output op,
    output vew,
    output opa,
    output opb,
    input  ready
  );

  modport consumer (
    input  valid,
    input  op,
    input  vew,
    input  opa,
    input  opb,
    output ready
  );

endinterface

//--- alu_issue.sv
// ALU issue stage
// Follows the four-phase input handshake and pushes operations into the queue

`timescale 1ns/1ps

module alu_issue (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_i,
  input  alu_op_pkg::alu_op_e  op_i,
  input  simd_lane_pkg::vew_e  vew_i,
  input  simd_lane_pkg::elen_t opa_i,
  input  simd_lane_pkg::elen_t opb_i,
  output logic                 ack_o,
  alu_op_if.producer           push
);

  typedef enum logic {
    ISS_IDLE = 1'b0,
    ISS_ACK  = 1'b1
  } iss_state_e;

  iss_state_e state_q;
  iss_state_e state_d;

  // Payload is stable while req_i is high
  assign push.valid = req_i && (state_q == ISS_IDLE);
  assign push.op    = op_i;
  assign push.vew   = vew_i;
  assign push.opa   = opa_i;
  assign push.opb   = opb_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ISS_IDLE: begin
        // Waits here while the queue is full
        if (push.valid && push.ready) begin
          state_d = ISS_ACK;
        end
      end
      ISS_ACK: begin
        if (!req_i) begin
          state_d = ISS_IDLE;
        end
      end
      default: state_d = ISS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ISS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ack_o = (state_q == ISS_ACK);

  // Request held until acknowledged, so ack rises only while req is high
  a_req_held : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_i && !ack_o |=> req_i || ack_o
  );

endmodule

//--- alu_op_fifo.sv
// Operation queue
// Circular buffer of pending ALU operations between issue and execution

`timescale 1ns/1ps

`include "simd_alu_consts.svh"

module alu_op_fifo #(
  parameter int unsigned DEPTH = `SIMD_OP_FIFO_DEPTH
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  alu_op_if.consumer wr,
  alu_op_if.producer rd
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  alu_op_pkg::alu_op_e  op_mem  [DEPTH];
  simd_lane_pkg::vew_e  vew_mem [DEPTH];
  simd_lane_pkg::elen_t opa_mem [DEPTH];
  simd_lane_pkg::elen_t opb_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr.ready = (count_q != CNT_W'(DEPTH));
  assign rd.valid = (count_q != '0);
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  assign rd.op  = op_mem[rd_ptr_q];
  assign rd.vew = vew_mem[rd_ptr_q];
  assign rd.opa = opa_mem[rd_ptr_q];
  assign rd.opb = opb_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]  <= wr.op;
      vew_mem[wr_ptr_q] <= wr.vew;
      opa_mem[wr_ptr_q] <= wr.opa;
      opb_mem[wr_ptr_q] <= wr.opb;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // No push while full, with full taken from the pointers
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push |-> !((wr_ptr_q == rd_ptr_q) && (count_q != '0))
  );

  // No pop while empty, with empty taken from the pointers
  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pop |-> !((wr_ptr_q == rd_ptr_q) && (count_q != CNT_W'(DEPTH)))
  );

endmodule

//--- alu_lane_exec.sv
// SIMD lane execution
// Pops one operation, computes the lane-wise result and saturation flags,
// and presents them on the four-phase result port

`timescale 1ns/1ps

`include "simd_alu_consts.svh"

module alu_lane_exec (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  alu_op_if.consumer            pop,
  input  logic                  res_ack_i,
  output logic                  res_req_o,
  output simd_lane_pkg::elen_t  result_o,
  output simd_lane_pkg::vxsat_t vxsat_o
);

  typedef enum logic [1:0] {
    EX_IDLE = 2'd0,
    EX_REQ  = 2'd1,
    EX_DONE = 2'd2
  } ex_state_e;

  ex_state_e             state_q;
  ex_state_e             state_d;
  logic                  take;
  simd_lane_pkg::elen_t  res_d;
  simd_lane_pkg::vxsat_t sat_d;

  ////////////////////////////////////////
  // Lane datapath
  ////////////////////////////////////////

  // One lane of lw bits, zero-extended; returns {sat, result}
  function automatic logic [`SIMD_ELEN:0] lane_calc(
    alu_op_pkg::alu_op_e  op,
    simd_lane_pkg::elen_t a,
    simd_lane_pkg::elen_t b,
    int unsigned          lw
  );
    simd_lane_pkg::elen_t msk;
    simd_lane_pkg::elen_t sgn;
    simd_lane_pkg::elen_t ax;
    simd_lane_pkg::elen_t bx;
    simd_lane_pkg::elen_t sh;
    simd_lane_pkg::elen_t res;
    logic [`SIMD_ELEN:0]  sum;
    logic                 sa;
    logic                 sb;
    logic                 sr;
    logic                 less;
    logic                 sat;

    // Shift by a full word yields zero, so 64-bit lanes get all ones
    msk  = (simd_lane_pkg::elen_t'(1) << lw) - simd_lane_pkg::elen_t'(1);
    sgn  = simd_lane_pkg::elen_t'(1) << (lw - 1);
    sa   = (a & sgn) != '0;
    sb   = (b & sgn) != '0;
    ax   = sa ? (a | ~msk) : a;
    bx   = sb ? (b | ~msk) : b;
    sum  = {1'b0, a} + {1'b0, b};
    sr   = (sum[`SIMD_ELEN-1:0] & sgn) != '0;
    sh   = a & simd_lane_pkg::elen_t'(lw - 1);
    less = alu_op_pkg::is_signed_cmp(op) ? ($signed(bx) < $signed(ax)) : (b < a);
    sat  = 1'b0;
    res  = '0;

    unique case (op)
      alu_op_pkg::VAND:  res = a & b;
      alu_op_pkg::VOR:   res = a | b;
      alu_op_pkg::VXOR:  res = a ^ b;
      alu_op_pkg::VADD:  res = sum[`SIMD_ELEN-1:0];
      alu_op_pkg::VSUB:  res = b - a;
      alu_op_pkg::VRSUB: res = a - b;
      alu_op_pkg::VSADDU: begin
        // Carry out of the lane
        sat = (sum >> lw) != '0;
        res = sat ? msk : sum[`SIMD_ELEN-1:0];
      end
      alu_op_pkg::VSADD: begin
        sat = (sa == sb) && (sr != sa);
        res = sat ? (sa ? sgn : (msk >> 1)) : sum[`SIMD_ELEN-1:0];
      end
      alu_op_pkg::VSSUBU: begin
        sat = a > b;
        res = sat ? '0 : (b - a);
      end
      alu_op_pkg::VMIN, alu_op_pkg::VMINU, alu_op_pkg::VMAX, alu_op_pkg::VMAXU: begin
        res = (less ^ alu_op_pkg::is_max(op)) ? b : a;
      end
      alu_op_pkg::VSLL: res = b << sh;
      alu_op_pkg::VSRL: res = b >> sh;
      alu_op_pkg::VSRA: res = $signed(bx) >>> sh;
      default:          res = '0;
    endcase

    return {sat, res & msk};
  endfunction

  always_comb begin : p_lanes
    logic [`SIMD_ELEN:0] lane;
    res_d = '0;
    sat_d = '0;
    lane  = '0;
    unique case (pop.vew)
      simd_lane_pkg::EW8: for (int l = 0; l < `SIMD_ELEN / 8; l++) begin
        lane = lane_calc(pop.op, simd_lane_pkg::elen_t'(pop.opa[8*l +: 8]),
                         simd_lane_pkg::elen_t'(pop.opb[8*l +: 8]), 8);
        res_d[8*l +: 8] = lane[7:0];
        sat_d[l]        = lane[`SIMD_ELEN];
      end
      simd_lane_pkg::EW16: for (int l = 0; l < `SIMD_ELEN / 16; l++) begin
        lane = lane_calc(pop.op, simd_lane_pkg::elen_t'(pop.opa[16*l +: 16]),
                         simd_lane_pkg::elen_t'(pop.opb[16*l +: 16]), 16);
        res_d[16*l +: 16] = lane[15:0];
        sat_d[2*l +: 2]   = {2{lane[`SIMD_ELEN]}};
      end
      simd_lane_pkg::EW32: for (int l = 0; l < `SIMD_ELEN / 32; l++) begin
        lane = lane_calc(pop.op, simd_lane_pkg::elen_t'(pop.opa[32*l +: 32]),
                         simd_lane_pkg::elen_t'(pop.opb[32*l +: 32]), 32);
        res_d[32*l +: 32] = lane[31:0];
        sat_d[4*l +: 4]   = {4{lane[`SIMD_ELEN]}};
      end
      default: begin
        lane  = lane_calc(pop.op, pop.opa, pop.opb, 64);
        res_d = lane[`SIMD_ELEN-1:0];
        sat_d = {`SIMD_STRB_W{lane[`SIMD_ELEN]}};
      end
    endcase
  end

  ////////////////////////////////////////
  // Result handshake
  ////////////////////////////////////////

  // Slot frees up in the cycle res_ack_i is seen low
  assign pop.ready = (state_q == EX_IDLE) || ((state_q == EX_DONE) && !res_ack_i);
  assign take      = pop.valid && pop.ready;
  assign res_req_o = (state_q == EX_REQ);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      EX_IDLE: if (take) state_d = EX_REQ;
      EX_REQ:  if (res_ack_i) state_d = EX_DONE;
      EX_DONE: if (!res_ack_i) state_d = take ? EX_REQ : EX_IDLE;
      default: state_d = EX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= EX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      result_o <= res_d;
      vxsat_o  <= sat_d;
    end
  end

  // Result held for the whole request phase
  a_result_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    res_req_o |=> $stable(result_o) && $stable(vxsat_o)
  );

endmodule

//--- simd_alu_top.sv
// SIMD integer ALU
// Four-phase operation input, operation queue, lane-wise execution
// and four-phase result output

`timescale 1ns/1ps

`include "simd_alu_consts.svh"

module simd_alu_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  alu_op_pkg::alu_op_e   op_i,
  input  simd_lane_pkg::vew_e   vew_i,
  input  simd_lane_pkg::elen_t  opa_i,
  input  simd_lane_pkg::elen_t  opb_i,
  output logic                  ack_o,
  output logic                  res_req_o,
  input  logic                  res_ack_i,
  output simd_lane_pkg::elen_t  result_o,
  output simd_lane_pkg::vxsat_t vxsat_o
);

  alu_op_if issue_q ();
  alu_op_if exec_q ();

  alu_issue i_issue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .op_i     (op_i),
    .vew_i    (vew_i),
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .ack_o    (ack_o),
    .push     (issue_q.producer)
  );

  alu_op_fifo #(
    .DEPTH (`SIMD_OP_FIFO_DEPTH)
  ) i_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wr       (issue_q.consumer),
    .rd       (exec_q.producer)
  );

  alu_lane_exec i_exec (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .pop       (exec_q.consumer),
    .res_ack_i (res_ack_i),
    .res_req_o (res_req_o),
    .result_o  (result_o),
    .vxsat_o   (vxsat_o)
  );

endmodule

//--- tb_simd_alu.sv
// SIMD ALU testbench
// Directed tests of all lane-wise operations, element widths and
// the four-phase ports, checked against a lane-level reference model

`timescale 1ns/1ps

`include "simd_alu_consts.svh"

module tb_simd_alu;

  localparam int TIMEOUT = 200;

  logic                  clk;
  logic                  arst_n;
  logic                  req;
  alu_op_pkg::alu_op_e   op;
  simd_lane_pkg::vew_e   vew;
  simd_lane_pkg::elen_t  opa;
  simd_lane_pkg::elen_t  opb;
  logic                  ack_o;
  logic                  res_req_o;
  logic                  res_ack;
  simd_lane_pkg::elen_t  result_o;
  simd_lane_pkg::vxsat_t vxsat_o;

  logic [31:0]           lfsr_q;
  int                    checks;
  int                    errors;
  simd_lane_pkg::elen_t  exp_res_q[$];
  simd_lane_pkg::vxsat_t exp_sat_q[$];

  simd_alu_top i_dut (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .req_i     (req),
    .op_i      (op),
    .vew_i     (vew),
    .opa_i     (opa),
    .opb_i     (opb),
    .ack_o     (ack_o),
    .res_req_o (res_req_o),
    .res_ack_i (res_ack),
    .result_o  (result_o),
    .vxsat_o   (vxsat_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus and reference
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output simd_lane_pkg::elen_t w);
    for (int i = 0; i < `SIMD_ELEN; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  // Lanes are widened to 66 bits so no result overflows
  function automatic void ref_model(
    input  alu_op_pkg::alu_op_e   f_op,
    input  simd_lane_pkg::vew_e   f_vew,
    input  simd_lane_pkg::elen_t  a,
    input  simd_lane_pkg::elen_t  b,
    output simd_lane_pkg::elen_t  res,
    output simd_lane_pkg::vxsat_t sat
  );
    int unsigned        lw;
    int                 amt;
    logic [65:0]        mask;
    logic [65:0]        ua;
    logic [65:0]        ub;
    logic [65:0]        uv;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] sv;
    logic signed [65:0] hi;
    logic signed [65:0] lo;
    logic               flag;

    lw   = 8 << f_vew;
    mask = (66'd1 << lw) - 66'd1;
    hi   = (66'sd1 <<< (lw - 1)) - 66'sd1;
    lo   = -hi - 66'sd1;
    res  = '0;
    sat  = '0;
    for (int base = 0; base < `SIMD_ELEN; base += lw) begin
      ua   = (66'(a) >> base) & mask;
      ub   = (66'(b) >> base) & mask;
      sa   = $signed(ua) - (ua[lw-1] ? (66'sd1 <<< lw) : 66'sd0);
      sb   = $signed(ub) - (ub[lw-1] ? (66'sd1 <<< lw) : 66'sd0);
      amt  = int'(ua % lw);
      flag = 1'b0;
      uv   = '0;
      case (f_op)
        alu_op_pkg::VAND:   uv = ua & ub;
        alu_op_pkg::VOR:    uv = ua | ub;
        alu_op_pkg::VXOR:   uv = ua ^ ub;
        alu_op_pkg::VADD:   uv = ua + ub;
        alu_op_pkg::VSUB:   uv = ub - ua;
        alu_op_pkg::VRSUB:  uv = ua - ub;
        alu_op_pkg::VSADDU: begin
          uv   = ua + ub;
          flag = uv > mask;
          if (flag) uv = mask;
        end
        alu_op_pkg::VSADD: begin
          sv   = sa + sb;
          flag = (sv > hi) || (sv < lo);
          if (sv > hi) sv = hi;
          if (sv < lo) sv = lo;
          uv   = sv;
        end
        alu_op_pkg::VSSUBU: begin
          flag = ub < ua;
          uv   = flag ? 66'd0 : (ub - ua);
        end
        alu_op_pkg::VMIN:   uv = (sa < sb) ? sa : sb;
        alu_op_pkg::VMINU:  uv = (ua < ub) ? ua : ub;
        alu_op_pkg::VMAX:   uv = (sa > sb) ? sa : sb;
        alu_op_pkg::VMAXU:  uv = (ua > ub) ? ua : ub;
        alu_op_pkg::VSLL:   uv = ub << amt;
        alu_op_pkg::VSRL:   uv = ub >> amt;
        alu_op_pkg::VSRA: begin
          sv = sb >>> amt;
          uv = sv;
        end
        default:            uv = '0;
      endcase
      res |= 64'(uv & mask) << base;
      if (flag) begin
        sat |= simd_lane_pkg::vxsat_t'(((1 << (lw / 8)) - 1) << (base / 8));
      end
    end
  endfunction

  ////////////////////////////////////////
  // Checks and run control
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_run();
    $display("sim failed");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    errors++;
    $display("Timed out waiting for %s at %0t", what, $time);
    $display("Checks: %0d, errors: %0d", checks, errors);
    fail_run();
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack_o !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ack_o !== level) timeout_abort("ack_o");
  endtask

  task automatic wait_res_req(input logic level);
    int n;
    n = 0;
    while (res_req_o !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (res_req_o !== level) timeout_abort("res_req_o");
  endtask

  ////////////////////////////////////////
  // Port handshakes
  ////////////////////////////////////////

  // Payload first, then req
  task automatic begin_request(input alu_op_pkg::alu_op_e o, input simd_lane_pkg::vew_e w,
                               input simd_lane_pkg::elen_t a, input simd_lane_pkg::elen_t b);
    simd_lane_pkg::elen_t  r;
    simd_lane_pkg::vxsat_t s;
    ref_model(o, w, a, b, r, s);
    exp_res_q.push_back(r);
    exp_sat_q.push_back(s);
    op  = o;
    vew = w;
    opa = a;
    opb = b;
    req = 1'b1;
  endtask

  task automatic finish_request();
    wait_ack(1'b1);
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic send_op(input alu_op_pkg::alu_op_e o, input simd_lane_pkg::vew_e w,
                         input simd_lane_pkg::elen_t a, input simd_lane_pkg::elen_t b);
    begin_request(o, w, a, b);
    finish_request();
  endtask

  task automatic get_result();
    wait_res_req(1'b1);
    if (exp_res_q.size() == 0) begin
      errors++;
      $display("Result arrived at %0t with no operation outstanding", $time);
    end else begin
      check_value("result_o", result_o, exp_res_q.pop_front());
      check_value("vxsat_o", 64'(vxsat_o), 64'(exp_sat_q.pop_front()));
    end
    res_ack = 1'b1;
    wait_res_req(1'b0);
    res_ack = 1'b0;
  endtask

  task automatic run_op(input alu_op_pkg::alu_op_e o, input simd_lane_pkg::vew_e w,
                        input simd_lane_pkg::elen_t a, input simd_lane_pkg::elen_t b);
    send_op(o, w, a, b);
    get_result();
  endtask

  task automatic run_random(input alu_op_pkg::alu_op_e o, input simd_lane_pkg::vew_e w);
    simd_lane_pkg::elen_t a;
    simd_lane_pkg::elen_t b;
    rand_word(a);
    rand_word(b);
    run_op(o, w, a, b);
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s finished with %0d errors", name, errors - err_start);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic logical_ops();
    alu_op_pkg::alu_op_e ops[3] = '{alu_op_pkg::VAND, alu_op_pkg::VOR, alu_op_pkg::VXOR};
    int                  err_start;
    err_start = errors;
    for (int w = 0; w < 4; w++) begin
      foreach (ops[i]) run_random(ops[i], simd_lane_pkg::vew_e'(w));
    end
    report_test("logical", err_start);
  endtask

  task automatic wrapping_arith();
    alu_op_pkg::alu_op_e ops[3] = '{alu_op_pkg::VADD, alu_op_pkg::VSUB, alu_op_pkg::VRSUB};
    int                  err_start;
    err_start = errors;
    for (int w = 0; w < 4; w++) begin
      foreach (ops[i]) begin
        // All-ones plus ones per byte, carries must stop at lane edges
        run_op(ops[i], simd_lane_pkg::vew_e'(w), '1, 64'h0101_0101_0101_0101);
        run_random(ops[i], simd_lane_pkg::vew_e'(w));
      end
    end
    report_test("wrapping arithmetic", err_start);
  endtask

  task automatic saturating_arith();
    alu_op_pkg::alu_op_e ops[3] = '{alu_op_pkg::VSADDU, alu_op_pkg::VSADD, alu_op_pkg::VSSUBU};
    int                  err_start;
    err_start = errors;
    run_op(alu_op_pkg::VSADDU, simd_lane_pkg::EW8, 64'hFF80_0102_7F01_FE00,
           64'h0180_FF02_8100_0300);
    run_op(alu_op_pkg::VSADD, simd_lane_pkg::EW16, 64'h7FFF_8000_4000_0001,
           64'h0001_FFFF_4000_7FFF);
    run_op(alu_op_pkg::VSSUBU, simd_lane_pkg::EW32, 64'h0000_0005_FFFF_FFFF,
           64'h0000_0004_0000_0001);
    run_op(alu_op_pkg::VSADD, simd_lane_pkg::EW64, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1);
    run_op(alu_op_pkg::VSADDU, simd_lane_pkg::EW64, '1, 64'd2);
    for (int w = 0; w < 4; w++) begin
      foreach (ops[i]) run_random(ops[i], simd_lane_pkg::vew_e'(w));
    end
    report_test("saturating arithmetic", err_start);
  endtask

  task automatic min_max();
    alu_op_pkg::alu_op_e ops[4] = '{alu_op_pkg::VMIN, alu_op_pkg::VMINU,
                                    alu_op_pkg::VMAX, alu_op_pkg::VMAXU};
    int                  err_start;
    err_start = errors;
    for (int w = 0; w < 4; w++) begin
      foreach (ops[i]) begin
        run_op(ops[i], simd_lane_pkg::vew_e'(w), 64'h80FF_7F01_8000_0001,
               64'h7F00_80FF_0001_8000);
        run_random(ops[i], simd_lane_pkg::vew_e'(w));
      end
    end
    report_test("min and max", err_start);
  endtask

  task automatic shifts();
    alu_op_pkg::alu_op_e  ops[3] = '{alu_op_pkg::VSLL, alu_op_pkg::VSRL, alu_op_pkg::VSRA};
    simd_lane_pkg::elen_t a;
    int                   err_start;
    err_start = errors;
    for (int w = 0; w < 4; w++) begin
      foreach (ops[i]) begin
        rand_word(a);
        // Sign bit set in every lane
        run_op(ops[i], simd_lane_pkg::vew_e'(w), a, 64'h8080_8080_8080_8080);
        run_random(ops[i], simd_lane_pkg::vew_e'(w));
      end
    end
    report_test("shifts", err_start);
  endtask

  task automatic backpressure_order();
    alu_op_pkg::alu_op_e  ops[6] = '{alu_op_pkg::VADD, alu_op_pkg::VSADDU, alu_op_pkg::VMAX,
                                     alu_op_pkg::VSRA, alu_op_pkg::VXOR, alu_op_pkg::VSSUBU};
    simd_lane_pkg::elen_t a;
    simd_lane_pkg::elen_t b;
    int                   err_start;
    int                   acks;
    int                   extra;
    err_start = errors;
    // Four in the queue plus one in the execution slot
    for (int i = 0; i < 5; i++) begin
      rand_word(a);
      rand_word(b);
      send_op(ops[i], simd_lane_pkg::vew_e'(i % 4), a, b);
    end
    rand_word(a);
    rand_word(b);
    begin_request(ops[5], simd_lane_pkg::EW16, a, b);
    acks = 0;
    for (int c = 0; c < 12; c++) begin
      @(negedge clk);
      if (ack_o) acks++;
    end
    check_value("ack_o while full", 64'(acks), 64'd0);
    get_result();
    finish_request();
    for (int i = 1; i < 6; i++) get_result();
    // No seventh result may follow
    extra = 0;
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      if (res_req_o) extra++;
    end
    check_value("res_req_o after last result", 64'(extra), 64'd0);
    report_test("back-pressure and order", err_start);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    arst_n  = 1'b0;
    req     = 1'b0;
    op      = alu_op_pkg::VAND;
    vew     = simd_lane_pkg::EW8;
    opa     = '0;
    opb     = '0;
    res_ack = 1'b0;
    lfsr_q  = 32'd75454;
    checks  = 0;
    errors  = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    logical_ops();
    wrapping_arith();
    saturating_arith();
    min_max();
    shifts();
    backpressure_order();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

//--- compile.f
+incdir+.
simd_lane_pkg.sv
alu_op_pkg.sv
alu_op_if.sv
alu_issue.sv
alu_op_fifo.sv
alu_lane_exec.sv
simd_alu_top.sv
tb_simd_alu.sv

//--- Makefile
TOP := tb_simd_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
